/* vip_defs.svh */
`ifndef VIP_DEFS_SVH
`define VIP_DEFS_SVH

// ****************************************
// frame geometry
// ****************************************
`define H_DISP          16                          // active pixels per line (1024 on hw)
`define V_DISP          8                           // active lines per frame (768 on hw)

// ****************************************
// capture and edge tuning
// ****************************************
`define FRAME_SKIP      2                           // whole frames dropped after reset
`define SOBEL_THRESHOLD 96                          // edge when |gx|+|gy| is above this

// ****************************************
// counter widths
// ****************************************
`define COL_W           ($clog2(`H_DISP))           // column count 0..H_DISP-1
`define ROW_W           ($clog2(`V_DISP))           // row count 0..V_DISP-1
`define SKIP_W          ($clog2(`FRAME_SKIP + 2))   // holds 0..FRAME_SKIP

`endif

/* vip_pkg.sv */
package vip_pkg;

    // 5:6:5 packing, red in the msbs
    typedef struct packed {
        logic [4:0] r;                      // red
        logic [5:0] g;                      // green
        logic [4:0] b;                      // blue
    } rgb565_t;

    typedef logic [7:0] gray_t;             // luma byte

    typedef struct packed {
        logic  sync;                        // frame sync, delayed with data
        logic  valid;                       // one cycle per pixel
        gray_t y;
    } gray_pix_t;

    // 3x3 neighbourhood, p<row><col>, row 0 on top, col 0 on the left
    typedef struct packed {
        gray_t p00;
        gray_t p01;
        gray_t p02;
        gray_t p10;
        gray_t p11;                         // centre
        gray_t p12;
        gray_t p20;
        gray_t p21;
        gray_t p22;
    } window_t;

    typedef enum logic [1:0] {
        cap_wait_vsync,                     // idle until first frame edge
        cap_skip,                           // sensor settling
        cap_run                             // pixels pass through
    } cap_state_t;

endpackage

/* pixel_if.sv */
`timescale 1ns/10ps

interface pixel_if import vip_pkg::*; ();

    logic    vsync;                         // frame sync
    logic    href;                          // line active
    logic    de;                            // pixel strobe, one cycle each
    rgb565_t data;                          // pixel

    // capture side
    modport source (
        output vsync,
        output href,
        output de,
        output data
    );

    // processing side
    modport sink (
        input  vsync,
        input  href,
        input  de,
        input  data
    );

endinterface

/* cmos_capture.sv */
`timescale 1ns/10ps
`include "vip_defs.svh"

module cmos_capture import vip_pkg::*; (
    input  logic       cam_pclk,                    // camera pixel clock
    input  logic       rst_n,                       // sync reset, active low
    input  logic       cam_vsync,                   // sensor frame sync
    input  logic       cam_href,                    // sensor line valid
    input  logic [7:0] cam_data,                    // one byte per pclk
    pixel_if.source    pix                          // paired rgb565 stream
);

    localparam int            SW        = `SKIP_W;
    localparam logic [SW-1:0] SKIP_LAST = SW'(`FRAME_SKIP);

    logic          vsync_q;                         // sampled vsync
    logic          vsync_q2;                        // previous sample
    logic          href_q;                          // sampled href
    logic [7:0]    data_q;                          // sampled byte
    logic          vs_rise;                         // frame start
    logic          run;
    cap_state_t    state;
    logic [SW-1:0] skip_cnt;                        // frames seen while skipping
    logic          byte_phase;                      // 1 when low byte is due
    logic [7:0]    byte_hi;                         // held first byte
    logic          vsync_o;
    logic          href_o;
    logic          de_o;
    rgb565_t       data_o;

    // ****************************************
    // input sampling
    // ****************************************
    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            vsync_q  <= 1'b1;                       // preset high so a live vsync is no edge
            vsync_q2 <= 1'b1;
            href_q   <= 1'b0;
        end else begin
            vsync_q  <= cam_vsync;
            vsync_q2 <= vsync_q;
            href_q   <= cam_href;
        end
    end

    always_ff @(posedge cam_pclk) begin
        data_q <= cam_data;                         // byte lane
    end

    assign vs_rise = vsync_q & ~vsync_q2;
    assign run     = (state == cap_run);

    // ****************************************
    // frame skip FSM
    // ****************************************
    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            state    <= cap_wait_vsync;
            skip_cnt <= '0;
        end else begin
            case (state)
                cap_wait_vsync: if (vs_rise) begin
                    skip_cnt <= SW'(1);             // this frame is the first seen
                    state    <= (`FRAME_SKIP == 0) ? cap_run : cap_skip;
                end
                cap_skip: if (vs_rise) begin
                    if (skip_cnt == SKIP_LAST)
                        state <= cap_run;           // skipped frames done
                    else
                        skip_cnt <= skip_cnt + 1'b1;
                end
                default: state <= state;            // run until reset
            endcase
        end
    end

    // byte pairing, high byte first
    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            byte_phase <= 1'b0;
            vsync_o    <= 1'b0;
            href_o     <= 1'b0;
            de_o       <= 1'b0;
        end else begin
            vsync_o <= vsync_q2 & run;              // late copy catches the starting edge
            href_o  <= href_q & run;
            de_o    <= run & href_q & byte_phase;   // strobe on the low byte
            if (run && href_q)
                byte_phase <= ~byte_phase;
            else
                byte_phase <= 1'b0;                 // line gap realigns pairs
        end
    end

    always_ff @(posedge cam_pclk) begin
        if (run && href_q) begin
            if (!byte_phase)
                byte_hi <= data_q;                  // R5 G3
            else
                data_o  <= {byte_hi, data_q};       // G3 B5 completes the pixel
        end
    end

    assign pix.vsync = vsync_o;
    assign pix.href  = href_o;
    assign pix.de    = de_o;
    assign pix.data  = data_o;

endmodule

/* rgb_to_gray.sv */
`timescale 1ns/10ps

module rgb_to_gray import vip_pkg::*; (
    input  logic      cam_pclk,                     // pixel clock
    input  logic      rst_n,                        // sync reset, active low
    pixel_if.sink     pix,                          // rgb565 in
    output gray_pix_t gray                          // luma out, 2 cycles later
);

    logic [7:0]  r8;                                // colours stretched to 8 bits
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic        in_valid;
    logic [15:0] mul_r;                             // weighted terms
    logic [15:0] mul_g;
    logic [15:0] mul_b;
    logic [15:0] sum;
    logic        s1_sync;
    logic        s1_valid;
    logic        s2_sync;
    logic        s2_valid;
    gray_t       s2_y;

    // repeat msbs into the low bits
    assign r8       = {pix.data.r, pix.data.r[4:2]};
    assign g8       = {pix.data.g, pix.data.g[5:4]};
    assign b8       = {pix.data.b, pix.data.b[4:2]};
    assign in_valid = pix.de & pix.href;            // strobe only counts inside a line

    // ****************************************
    // stage 1 products, stage 2 sum
    // ****************************************
    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            s1_sync  <= 1'b0;
            s1_valid <= 1'b0;
            s2_sync  <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_sync  <= pix.vsync;
            s1_valid <= in_valid;
            s2_sync  <= s1_sync;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge cam_pclk) begin
        mul_r <= 16'd77  * {8'd0, r8};              // weights sum to 256
        mul_g <= 16'd150 * {8'd0, g8};
        mul_b <= 16'd29  * {8'd0, b8};
        s2_y  <= sum[15:8];                         // divide by 256
    end

    assign sum  = mul_r + mul_g + mul_b;            // max 65280, no overflow
    assign gray = '{sync: s2_sync, valid: s2_valid, y: s2_y};

endmodule

/* line_window.sv */
`timescale 1ns/10ps
`include "vip_defs.svh"

module line_window import vip_pkg::*; (
    input  logic      cam_pclk,                     // pixel clock
    input  logic      rst_n,                        // sync reset, active low
    input  gray_pix_t gray,                         // luma stream
    output window_t   win,                          // 3x3 around (row-1, col-1)
    output logic      win_valid                     // interior pixels only
);

    localparam int            CW       = `COL_W;
    localparam int            RW       = `ROW_W;
    localparam logic [CW-1:0] COL_LAST = CW'(`H_DISP - 1);
    localparam logic [CW-1:0] COL_TWO  = CW'(2);
    localparam logic [RW-1:0] ROW_TWO  = RW'(2);

    gray_t         line1 [`H_DISP];                 // previous line
    gray_t         line2 [`H_DISP];                 // two lines back
    logic          sync_q;
    logic          frame_start;
    logic [CW-1:0] col;
    logic [RW-1:0] row;
    gray_t         tap1;                            // pixel one line up
    gray_t         tap2;                            // pixel two lines up
    logic          interior;
    window_t       win_q;
    logic          win_valid_q;

    assign frame_start = gray.sync & ~sync_q;
    assign interior    = (row >= ROW_TWO) && (col >= COL_TWO);

    // ****************************************
    // raster position
    // ****************************************
    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            sync_q      <= 1'b0;
            col         <= '0;
            row         <= '0;
            win_valid_q <= 1'b0;
        end else begin
            sync_q      <= gray.sync;
            win_valid_q <= gray.valid & interior;   // borders never leave
            if (frame_start) begin
                col <= '0;
                row <= '0;
            end else if (gray.valid) begin
                if (col == COL_LAST) begin
                    col <= '0;                      // wrap to next line
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // ****************************************
    // line buffers and 3x3 shift
    // ****************************************
    assign tap1 = line1[col];
    assign tap2 = line2[col];

    always_ff @(posedge cam_pclk) begin
        if (gray.valid) begin
            line2[col] <= tap1;                     // older line moves down a slot
            line1[col] <= gray.y;
            win_q.p00  <= win_q.p01;                // top row
            win_q.p01  <= win_q.p02;
            win_q.p02  <= tap2;
            win_q.p10  <= win_q.p11;                // middle row
            win_q.p11  <= win_q.p12;
            win_q.p12  <= tap1;
            win_q.p20  <= win_q.p21;                // bottom row, current line
            win_q.p21  <= win_q.p22;
            win_q.p22  <= gray.y;
        end
    end

    assign win       = win_q;
    assign win_valid = win_valid_q;

endmodule

/* sobel_edge.sv */
`timescale 1ns/10ps
`include "vip_defs.svh"

module sobel_edge import vip_pkg::*; (
    input  logic    cam_pclk,                       // pixel clock
    input  logic    rst_n,                          // sync reset, active low
    input  window_t win,                            // 3x3 luma
    input  logic    win_valid,
    input  logic    frame_sync,                     // sync from the gray stage
    output logic    post_vsync,
    output logic    post_de,
    output rgb565_t post_rgb                        // white on edge, black otherwise
);

    localparam logic [10:0] THRESH = 11'(`SOBEL_THRESHOLD);

    logic [9:0]         gx_pos;                     // right column, 1-2-1
    logic [9:0]         gx_neg;                     // left column
    logic [9:0]         gy_pos;                     // bottom row
    logic [9:0]         gy_neg;                     // top row
    logic signed [10:0] gx;
    logic signed [10:0] gy;
    logic               s1_valid;
    logic [1:0]         sync_pipe;                  // window stage + stage 1
    logic [10:0]        abs_x;
    logic [10:0]        abs_y;
    logic [10:0]        mag;                        // up to 2040
    logic               is_edge;

    // ****************************************
    // stage 1 gradients
    // ****************************************
    assign gx_pos = {2'b00, win.p02} + {1'b0, win.p12, 1'b0} + {2'b00, win.p22};
    assign gx_neg = {2'b00, win.p00} + {1'b0, win.p10, 1'b0} + {2'b00, win.p20};
    assign gy_pos = {2'b00, win.p20} + {1'b0, win.p21, 1'b0} + {2'b00, win.p22};
    assign gy_neg = {2'b00, win.p00} + {1'b0, win.p01, 1'b0} + {2'b00, win.p02};

    always_ff @(posedge cam_pclk) begin
        gx <= $signed({1'b0, gx_pos}) - $signed({1'b0, gx_neg});
        gy <= $signed({1'b0, gy_pos}) - $signed({1'b0, gy_neg});
    end

    // ****************************************
    // stage 2 magnitude and threshold
    // ****************************************
    assign abs_x   = gx[10] ? -gx : gx;
    assign abs_y   = gy[10] ? -gy : gy;
    assign mag     = abs_x + abs_y;                 // L1 norm
    assign is_edge = mag > THRESH;

    always_ff @(posedge cam_pclk) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            sync_pipe  <= 2'b00;
            post_vsync <= 1'b0;
            post_de    <= 1'b0;
            post_rgb   <= 16'h0000;
        end else begin
            s1_valid   <= win_valid;
            sync_pipe  <= {sync_pipe[0], frame_sync};
            post_vsync <= sync_pipe[1];             // 3 stages, same as the pixels
            post_de    <= s1_valid;
            if (s1_valid)
                post_rgb <= is_edge ? 16'hffff : 16'h0000;
        end
    end

endmodule

/* vip_top.sv */
`timescale 1ns/10ps

module vip_top import vip_pkg::*; (
    input  logic        cam_pclk,                   // camera pixel clock
    input  logic        rst_n,                      // sync reset, active low
    input  logic        cam_vsync,                  // sensor frame sync
    input  logic        cam_href,                   // sensor line valid
    input  logic [7:0]  cam_data,                   // sensor byte bus
    output logic        post_vsync,                 // processed frame sync
    output logic        post_de,                    // processed pixel strobe
    output logic [15:0] post_rgb                    // edge pixel, rgb565
);

    pixel_if   pix_bus ();                          // capture to gray
    gray_pix_t gray;                                // gray to window
    window_t   win;                                 // window to sobel
    logic      win_valid;

    // ****************************************
    // camera to edge chain
    // ****************************************
    cmos_capture u_cmos_capture (
        .cam_pclk   (cam_pclk),
        .rst_n      (rst_n),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .pix        (pix_bus.source)
    );

    rgb_to_gray u_rgb_to_gray (
        .cam_pclk   (cam_pclk),
        .rst_n      (rst_n),
        .pix        (pix_bus.sink),
        .gray       (gray)
    );

    line_window u_line_window (
        .cam_pclk   (cam_pclk),
        .rst_n      (rst_n),
        .gray       (gray),
        .win        (win),
        .win_valid  (win_valid)
    );

    sobel_edge u_sobel_edge (
        .cam_pclk   (cam_pclk),
        .rst_n      (rst_n),
        .win        (win),
        .win_valid  (win_valid),
        .frame_sync (gray.sync),                    // sobel adds the window stage
        .post_vsync (post_vsync),
        .post_de    (post_de),
        .post_rgb   (post_rgb)
    );

endmodule

/* tb_vip.sv */
`timescale 1ns/10ps
`include "vip_defs.svh"

module tb_vip import vip_pkg::*; ();

    localparam int H           = `H_DISP;
    localparam int V           = `V_DISP;
    localparam int NPIX        = H * V;
    localparam int N_INT       = (H - 2) * (V - 2);             // windows per frame
    localparam int N_RUN       = 4;                             // frames checked after the skip
    localparam int MODE_RANDOM = 0;
    localparam int MODE_FLAT   = 1;
    localparam int MODE_EDGE   = 2;

    typedef rgb565_t pix_q_t [$];

    logic        cam_pclk = 1'b0;
    logic        rst_n;
    logic        cam_vsync;
    logic        cam_href;
    logic [7:0]  cam_data;
    logic        post_vsync;
    logic        post_de;
    logic [15:0] post_rgb;

    logic [15:0] lfsr;                                          // random source state
    rgb565_t     img [NPIX];                                    // frame about to be sent
    pix_q_t      exp_q;                                         // expected edge pixels
    int          checks     = 0;
    int          mismatches = 0;
    int          failures   = 0;                                // non-value errors
    int          frames_out = 0;                                // post_vsync rising edges
    int          de_cnt     = 0;
    logic        vsync_prev = 1'b0;

    vip_top dut (
        .cam_pclk   (cam_pclk),
        .rst_n      (rst_n),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .post_vsync (post_vsync),
        .post_de    (post_de),
        .post_rgb   (post_rgb)
    );

    always #50 cam_pclk = ~cam_pclk;                            // 100 ns period

    // ****************************************
    // random numbers
    // ****************************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};                        // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************
    function automatic pix_q_t ref_edges(input rgb565_t frame [NPIX]);
        int     y [NPIX];
        int     r8;
        int     g8;
        int     b8;
        int     gx;
        int     gy;
        pix_q_t edges;
        for (int i = 0; i < NPIX; i++) begin
            r8   = (int'(frame[i].r) << 3) | (int'(frame[i].r) >> 2);  // 5 to 8 bits
            g8   = (int'(frame[i].g) << 2) | (int'(frame[i].g) >> 4);  // 6 to 8 bits
            b8   = (int'(frame[i].b) << 3) | (int'(frame[i].b) >> 2);
            y[i] = (77 * r8 + 150 * g8 + 29 * b8) / 256;
        end
        for (int r = 1; r < V - 1; r++) begin
            for (int c = 1; c < H - 1; c++) begin
                gx = y[(r-1)*H + c+1] + 2 * y[r*H + c+1] + y[(r+1)*H + c+1]
                   - y[(r-1)*H + c-1] - 2 * y[r*H + c-1] - y[(r+1)*H + c-1];
                gy = y[(r+1)*H + c-1] + 2 * y[(r+1)*H + c] + y[(r+1)*H + c+1]
                   - y[(r-1)*H + c-1] - 2 * y[(r-1)*H + c] - y[(r-1)*H + c+1];
                if (gx < 0) gx = -gx;
                if (gy < 0) gy = -gy;
                edges.push_back((gx + gy > `SOBEL_THRESHOLD) ? rgb565_t'(16'hffff)
                                                              : rgb565_t'(16'h0000));
            end
        end
        return edges;
    endfunction

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic compare_rgb(input string name, input rgb565_t exp, input rgb565_t got);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected 0x%h got 0x%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int got);
        checks++;
        if (got != exp) begin
            mismatches++;
            $display("Mismatch %s: expected 0x%h got 0x%h at %0t", name, exp, got, $time);
        end
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    task automatic fill_frame(input int mode);
        logic [15:0] bits;
        rgb565_t     flat;
        draw_bits(16, bits);
        flat = rgb565_t'(bits);                                 // one colour for the flat frame
        for (int i = 0; i < NPIX; i++) begin
            case (mode)
                MODE_RANDOM: begin
                    draw_bits(16, bits);
                    img[i] = rgb565_t'(bits);
                end
                MODE_FLAT: img[i] = flat;
                default:   img[i] = ((i % H) < H / 2) ? rgb565_t'(16'h0000)   // black left
                                                      : rgb565_t'(16'hffff);  // white right
            endcase
        end
    endtask

    task automatic queue_expected();
        pix_q_t edges;
        edges = ref_edges(img);
        foreach (edges[i]) exp_q.push_back(edges[i]);
    endtask

    task automatic pulse_vsync();
        repeat (4) begin
            @(posedge cam_pclk);
            cam_vsync <= 1'b1;
            cam_href  <= 1'b0;
        end
        repeat (6) begin
            @(posedge cam_pclk);
            cam_vsync <= 1'b0;
        end
    endtask

    task automatic send_frame();
        logic [15:0] gap;
        pulse_vsync();
        for (int r = 0; r < V; r++) begin
            for (int c = 0; c < H; c++) begin
                @(posedge cam_pclk);
                cam_href <= 1'b1;
                cam_data <= img[r*H + c][15:8];                 // high byte first
                @(posedge cam_pclk);
                cam_data <= img[r*H + c][7:0];
                if (c != H - 1) begin
                    draw_bits(2, gap);                          // 0..3 idle cycles
                    repeat (gap) begin
                        @(posedge cam_pclk);
                        cam_href <= 1'b0;
                        cam_data <= 8'h00;
                    end
                end
            end
            repeat (8) begin
                @(posedge cam_pclk);
                cam_href <= 1'b0;                               // line blanking
            end
        end
        repeat (12) @(posedge cam_pclk);                        // frame blanking
    endtask

    task automatic wait_drain(input int frames, input int limit);
        int cyc;
        cyc = 0;
        while ((frames_out < frames || exp_q.size() != 0) && cyc < limit) begin
            @(posedge cam_pclk);
            cyc++;
        end
        if (frames_out < frames || exp_q.size() != 0) begin
            failures++;
            $display("Timeout: %0d expected pixels never came out, %0d frames seen",
                     exp_q.size(), frames_out);
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        lfsr      = 16'd62987;
        rst_n     = 1'b0;
        cam_vsync = 1'b1;                                       // high through reset, no edge
        cam_href  = 1'b0;
        cam_data  = 8'h00;
        repeat (16) @(posedge cam_pclk);
        rst_n <= 1'b1;
        repeat (8) @(posedge cam_pclk);
        cam_vsync <= 1'b0;
        repeat (8) @(posedge cam_pclk);
        for (int f = 0; f < `FRAME_SKIP; f++) begin
            fill_frame(MODE_RANDOM);                            // dropped by capture
            send_frame();
        end
        fill_frame(MODE_RANDOM);
        queue_expected();
        send_frame();
        fill_frame(MODE_RANDOM);
        queue_expected();
        send_frame();
        fill_frame(MODE_FLAT);
        queue_expected();
        send_frame();
        fill_frame(MODE_EDGE);
        queue_expected();
        send_frame();
        pulse_vsync();                                          // closes the last frame count
        wait_drain(N_RUN + 1, 2000);
        compare_count("post_vsync frames", N_RUN + 1, frames_out);
        repeat (4) @(posedge cam_pclk);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // output checker, sampled mid-cycle
    always @(negedge cam_pclk) begin
        if (post_vsync && !vsync_prev) begin
            if (frames_out > 0)
                compare_count("post_de count", N_INT, de_cnt);
            frames_out++;
            de_cnt = 0;
        end
        vsync_prev = post_vsync;
        if (frames_out == 0) begin                              // reset and skipped frames
            if (post_de !== 1'b0) begin
                failures++;
                $display("post_de was high before the first processed frame at %0t", $time);
            end
            compare_rgb("post_rgb", rgb565_t'(16'h0000), rgb565_t'(post_rgb));
        end else if (post_de) begin
            de_cnt++;
            if (exp_q.size() == 0) begin
                failures++;
                $display("post_de pulsed with no pixel expected at %0t", $time);
            end else begin
                compare_rgb("post_rgb", exp_q.pop_front(), rgb565_t'(post_rgb));
            end
        end
    end

endmodule

/* flist.f */
+incdir+.
vip_pkg.sv
pixel_if.sv
cmos_capture.sv
rgb_to_gray.sv
line_window.sv
sobel_edge.sv
vip_top.sv
tb_vip.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_vip -f flist.f -o tb_vip_sim \
    && ./obj_dir/tb_vip_sim | tee /dev/stderr | grep -q "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
